//--- hdl/vid_bus_pkg.sv
package vid_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    // Host register bus, byte addressed
    localparam int REGBUS_ADDR_W = 19;
    localparam int REG_DATA_W    = 8;

    // Memory bus, one 32-bit word per access
    localparam int MEM_DATA_W     = 32;
    localparam int MEM_LANES      = 4;
    localparam int MAINRAM_ADDR_W = 15;
    localparam int MAINRAM_WORDS  = 1 << MAINRAM_ADDR_W;

    // Word address on the memory bus, top bit is the character ROM half
    localparam int FETCH_ADDR_W = 16;

    // Palette
    localparam int PAL_IDX_W   = 8;
    localparam int PAL_DATA_W  = 16;
    localparam int PAL_RGB_W   = 12;
    localparam int PAL_ENTRIES = 1 << PAL_IDX_W;
    localparam int PAL_LANES   = PAL_DATA_W / REG_DATA_W;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    // 00000-1FFFF  main RAM
    // 20000-3FFFF  character ROM half, reads as zero
    // 40200-403FF  palette
    // all else     unmapped
    localparam int MAINRAM_TOP_BIT = 18;

    // Palette decode compares bits 18..9
    localparam int PAL_SEL_LSB = 9;
    localparam logic [REGBUS_ADDR_W-PAL_SEL_LSB-1:0] PAL_BASE = 10'h201;

    // Target of a host access, used again one cycle later for read data
    typedef enum logic [1:0] {
        TGT_NONE    = 2'd0,
        TGT_MAINRAM = 2'd1,
        TGT_PALETTE = 2'd2
    } bus_target_e;

endpackage

//--- hdl/regbus_decode.sv
`timescale 1ns/1ps

module regbus_decode (
    input  logic                                  strobe_i,
    input  logic                                  write_i,
    input  logic [vid_bus_pkg::REGBUS_ADDR_W-1:0] addr_i,
    input  logic [vid_bus_pkg::REG_DATA_W-1:0]    wrdata_i,

    output vid_bus_pkg::bus_target_e              target_o,
    output logic                                  rd_strobe_o,

    // Memory bus side
    output logic                                  mem_strobe_o,
    output logic                                  mem_write_o,
    output logic [vid_bus_pkg::FETCH_ADDR_W-1:0]  mem_word_addr_o,
    output logic [vid_bus_pkg::MEM_LANES-1:0]     mem_lanes_o,
    output logic [vid_bus_pkg::MEM_DATA_W-1:0]    mem_wrdata_o,

    // Palette side
    output logic                                  pal_write_o,
    output logic [vid_bus_pkg::PAL_IDX_W-1:0]     pal_entry_o,
    output logic [vid_bus_pkg::PAL_LANES-1:0]     pal_lanes_o,
    output logic [vid_bus_pkg::PAL_DATA_W-1:0]    pal_wrdata_o
);

    logic mainram_hit;
    logic pal_hit;

    ////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////

    // Whole lower half goes to the memory bus
    assign mainram_hit = (addr_i[vid_bus_pkg::MAINRAM_TOP_BIT] == 1'b0);
    assign pal_hit = (addr_i[vid_bus_pkg::REGBUS_ADDR_W-1:vid_bus_pkg::PAL_SEL_LSB]
                      == vid_bus_pkg::PAL_BASE);

    always_comb begin
        if (mainram_hit) begin
            target_o = vid_bus_pkg::TGT_MAINRAM;
        end else if (pal_hit) begin
            target_o = vid_bus_pkg::TGT_PALETTE;
        end else begin
            target_o = vid_bus_pkg::TGT_NONE;
        end
    end

    // Strobe qualification
    assign rd_strobe_o  = strobe_i && !write_i;
    assign mem_strobe_o = strobe_i && (target_o == vid_bus_pkg::TGT_MAINRAM);
    assign mem_write_o  = write_i;
    assign pal_write_o  = strobe_i && write_i && (target_o == vid_bus_pkg::TGT_PALETTE);

    ////////////////////////////////////////////////////////////
    // Lanes and write data
    ////////////////////////////////////////////////////////////

    assign mem_word_addr_o = addr_i[vid_bus_pkg::FETCH_ADDR_W+1:2];
    assign mem_lanes_o     = 4'b0001 << addr_i[1:0];
    assign mem_wrdata_o    = {vid_bus_pkg::MEM_LANES{wrdata_i}};

    // Two bytes per palette entry, odd address is the high byte
    assign pal_entry_o  = addr_i[vid_bus_pkg::PAL_IDX_W:1];
    assign pal_lanes_o  = addr_i[0] ? 2'b10 : 2'b01;
    assign pal_wrdata_o = {vid_bus_pkg::PAL_LANES{wrdata_i}};

endmodule

//--- hdl/main_ram.sv
`timescale 1ns/1ps

module main_ram (
    input  logic                                   clk,
    input  logic                                   we_i,
    input  logic [vid_bus_pkg::MAINRAM_ADDR_W-1:0] addr_i,
    input  logic [vid_bus_pkg::MEM_LANES-1:0]      lanes_i,
    input  logic [vid_bus_pkg::MEM_DATA_W-1:0]     wrdata_i,
    output logic [vid_bus_pkg::MEM_DATA_W-1:0]     rddata_o
);

    logic [vid_bus_pkg::MEM_DATA_W-1:0] mem [0:vid_bus_pkg::MAINRAM_WORDS-1];

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < vid_bus_pkg::MEM_LANES; i++) begin
                if (lanes_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wrdata_i[8*i +: 8];
                end
            end
        end
    end

    // Synchronous read, old data on a write to the same word
    always_ff @(posedge clk) begin
        rddata_o <= mem[addr_i];
    end

endmodule

//--- hdl/membus_arbiter.sv
`timescale 1ns/1ps

module membus_arbiter (
    input  logic                                 clk,
    input  logic                                 reset,

    // Host port, single-cycle strobe
    input  logic                                 host_strobe_i,
    input  logic                                 host_write_i,
    input  logic [vid_bus_pkg::FETCH_ADDR_W-1:0] host_addr_i,
    input  logic [vid_bus_pkg::MEM_LANES-1:0]    host_lanes_i,
    input  logic [vid_bus_pkg::MEM_DATA_W-1:0]   host_wrdata_i,
    output logic [vid_bus_pkg::MEM_DATA_W-1:0]   mem_rddata_o,

    // Renderer fetch port, request held until acknowledge
    input  logic                                 fetch_req_i,
    input  logic [vid_bus_pkg::FETCH_ADDR_W-1:0] fetch_addr_i,
    output logic                                 fetch_ack_o,
    output logic [vid_bus_pkg::MEM_DATA_W-1:0]   fetch_rddata_o
);

    logic [vid_bus_pkg::FETCH_ADDR_W-1:0] bus_addr;
    logic                                 mainram_sel;
    logic                                 ram_we;
    logic                                 fetch_grant;
    logic                                 mainram_sel_q;
    logic                                 fetch_ack_q;
    logic [vid_bus_pkg::MEM_DATA_W-1:0]   ram_rddata;
    logic [vid_bus_pkg::MEM_DATA_W-1:0]   bus_rddata;

    ////////////////////////////////////////////////////////////
    // Address mux, host first
    ////////////////////////////////////////////////////////////

    assign bus_addr    = host_strobe_i ? host_addr_i : fetch_addr_i;
    assign fetch_grant = fetch_req_i && !host_strobe_i;

    // Upper half of the word space is the old character ROM
    assign mainram_sel = !bus_addr[vid_bus_pkg::FETCH_ADDR_W-1];
    assign ram_we      = host_strobe_i && host_write_i && mainram_sel;

    main_ram u_main_ram (
        .clk      (clk),
        .we_i     (ram_we),
        .addr_i   (bus_addr[vid_bus_pkg::MAINRAM_ADDR_W-1:0]),
        .lanes_i  (host_lanes_i),
        .wrdata_i (host_wrdata_i),
        .rddata_o (ram_rddata)
    );

    ////////////////////////////////////////////////////////////
    // Acknowledge and read data pipeline
    ////////////////////////////////////////////////////////////

    // Both line up with the RAM read latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_ack_q   <= 1'b0;
            mainram_sel_q <= 1'b0;
        end else begin
            fetch_ack_q   <= fetch_grant;
            mainram_sel_q <= mainram_sel;
        end
    end

    assign bus_rddata = mainram_sel_q ? ram_rddata : '0;

    assign mem_rddata_o   = bus_rddata;
    assign fetch_rddata_o = bus_rddata;
    assign fetch_ack_o    = fetch_ack_q;

endmodule

//--- hdl/palette_ram.sv
`timescale 1ns/1ps

module palette_ram (
    input  logic                                clk,

    // Host write port
    input  logic                                we_i,
    input  logic [vid_bus_pkg::PAL_IDX_W-1:0]   wr_entry_i,
    input  logic [vid_bus_pkg::PAL_LANES-1:0]   lanes_i,
    input  logic [vid_bus_pkg::PAL_DATA_W-1:0]  wrdata_i,

    // Display lookup
    input  logic [vid_bus_pkg::PAL_IDX_W-1:0]   disp_idx_i,
    output logic [vid_bus_pkg::PAL_RGB_W-1:0]   disp_rgb_o,

    // Host readback
    input  logic [vid_bus_pkg::PAL_IDX_W-1:0]   rb_entry_i,
    output logic [vid_bus_pkg::PAL_DATA_W-1:0]  rb_data_o
);

    logic [vid_bus_pkg::PAL_DATA_W-1:0] pal [0:vid_bus_pkg::PAL_ENTRIES-1];
    logic [vid_bus_pkg::PAL_DATA_W-1:0] disp_entry;

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < vid_bus_pkg::PAL_LANES; i++) begin
                if (lanes_i[i]) begin
                    pal[wr_entry_i][8*i +: 8] <= wrdata_i[8*i +: 8];
                end
            end
        end
    end

    // Two read ports on the one array
    always_ff @(posedge clk) begin
        disp_entry <= pal[disp_idx_i];
        rb_data_o  <= pal[rb_entry_i];
    end

    // RGB sits in the low 12 bits of an entry
    assign disp_rgb_o = disp_entry[vid_bus_pkg::PAL_RGB_W-1:0];

endmodule

//--- hdl/rddata_select.sv
`timescale 1ns/1ps

module rddata_select (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rd_strobe_i,
    input  vid_bus_pkg::bus_target_e            target_i,
    input  logic [1:0]                          byte_sel_i,
    input  logic [vid_bus_pkg::MEM_DATA_W-1:0]  mem_rddata_i,
    input  logic [vid_bus_pkg::PAL_DATA_W-1:0]  pal_rddata_i,
    output logic [vid_bus_pkg::REG_DATA_W-1:0]  rddata_o,
    output logic                                rd_valid_o
);

    vid_bus_pkg::bus_target_e target_q;
    logic [1:0]               byte_sel_q;
    logic                     rd_valid_q;

    // Match the one-cycle RAM latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            target_q   <= vid_bus_pkg::TGT_NONE;
            byte_sel_q <= 2'b00;
            rd_valid_q <= 1'b0;
        end else begin
            target_q   <= target_i;
            byte_sel_q <= byte_sel_i;
            rd_valid_q <= rd_strobe_i;
        end
    end

    always_comb begin
        case (target_q)
            vid_bus_pkg::TGT_MAINRAM: rddata_o = mem_rddata_i[8*byte_sel_q +: 8];
            vid_bus_pkg::TGT_PALETTE: rddata_o = pal_rddata_i[8*byte_sel_q[0] +: 8];
            default:                  rddata_o = '0;
        endcase
    end

    assign rd_valid_o = rd_valid_q;

endmodule

//--- hdl/vid_bus_top.sv
`timescale 1ns/1ps

module vid_bus_top (
    input  logic                                  clk,
    input  logic                                  reset,

    // Host register bus
    input  logic                                  strobe_i,
    input  logic                                  write_i,
    input  logic [vid_bus_pkg::REGBUS_ADDR_W-1:0] addr_i,
    input  logic [vid_bus_pkg::REG_DATA_W-1:0]    wrdata_i,
    output logic [vid_bus_pkg::REG_DATA_W-1:0]    rddata_o,
    output logic                                  rd_valid_o,

    // Renderer fetch
    input  logic                                  fetch_req_i,
    input  logic [vid_bus_pkg::FETCH_ADDR_W-1:0]  fetch_addr_i,
    output logic                                  fetch_ack_o,
    output logic [vid_bus_pkg::MEM_DATA_W-1:0]    fetch_rddata_o,

    // Display palette lookup
    input  logic [vid_bus_pkg::PAL_IDX_W-1:0]     pal_idx_i,
    output logic [vid_bus_pkg::PAL_RGB_W-1:0]     pal_rgb_o
);

    vid_bus_pkg::bus_target_e             target;
    logic                                 rd_strobe;
    logic                                 mem_strobe;
    logic                                 mem_write;
    logic [vid_bus_pkg::FETCH_ADDR_W-1:0] mem_word_addr;
    logic [vid_bus_pkg::MEM_LANES-1:0]    mem_lanes;
    logic [vid_bus_pkg::MEM_DATA_W-1:0]   mem_wrdata;
    logic [vid_bus_pkg::MEM_DATA_W-1:0]   mem_rddata;
    logic                                 pal_write;
    logic [vid_bus_pkg::PAL_IDX_W-1:0]    pal_entry;
    logic [vid_bus_pkg::PAL_LANES-1:0]    pal_lanes;
    logic [vid_bus_pkg::PAL_DATA_W-1:0]   pal_wrdata;
    logic [vid_bus_pkg::PAL_DATA_W-1:0]   pal_rddata;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    regbus_decode u_regbus_decode (
        .strobe_i        (strobe_i),
        .write_i         (write_i),
        .addr_i          (addr_i),
        .wrdata_i        (wrdata_i),
        .target_o        (target),
        .rd_strobe_o     (rd_strobe),
        .mem_strobe_o    (mem_strobe),
        .mem_write_o     (mem_write),
        .mem_word_addr_o (mem_word_addr),
        .mem_lanes_o     (mem_lanes),
        .mem_wrdata_o    (mem_wrdata),
        .pal_write_o     (pal_write),
        .pal_entry_o     (pal_entry),
        .pal_lanes_o     (pal_lanes),
        .pal_wrdata_o    (pal_wrdata)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    membus_arbiter u_membus_arbiter (
        .clk            (clk),
        .reset          (reset),
        .host_strobe_i  (mem_strobe),
        .host_write_i   (mem_write),
        .host_addr_i    (mem_word_addr),
        .host_lanes_i   (mem_lanes),
        .host_wrdata_i  (mem_wrdata),
        .mem_rddata_o   (mem_rddata),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_rddata_o (fetch_rddata_o)
    );

    // Readback port follows the host address every cycle
    palette_ram u_palette_ram (
        .clk        (clk),
        .we_i       (pal_write),
        .wr_entry_i (pal_entry),
        .lanes_i    (pal_lanes),
        .wrdata_i   (pal_wrdata),
        .disp_idx_i (pal_idx_i),
        .disp_rgb_o (pal_rgb_o),
        .rb_entry_i (pal_entry),
        .rb_data_o  (pal_rddata)
    );

    ////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////

    rddata_select u_rddata_select (
        .clk          (clk),
        .reset        (reset),
        .rd_strobe_i  (rd_strobe),
        .target_i     (target),
        .byte_sel_i   (addr_i[1:0]),
        .mem_rddata_i (mem_rddata),
        .pal_rddata_i (pal_rddata),
        .rddata_o     (rddata_o),
        .rd_valid_o   (rd_valid_o)
    );

endmodule

//--- verif/vid_bus_assert.sv
`timescale 1ns/1ps

module vid_bus_assert (
    input logic clk,
    input logic reset,
    input logic strobe_i,
    input logic write_i,
    input logic mem_strobe_i,
    input logic rd_valid_i,
    input logic fetch_req_i,
    input logic fetch_ack_i
);

    // Read valid follows a read strobe by exactly one cycle
    rd_valid_after_read: assert property (@(posedge clk) disable iff (reset)
        rd_valid_i |-> $past(strobe_i && !write_i))
        else $error("rd_valid_o without a read strobe one cycle earlier");

    // Acknowledge needs a request in the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        fetch_ack_i |-> $past(fetch_req_i))
        else $error("fetch_ack_o without a fetch request one cycle earlier");

    // Host owns the memory bus
    host_blocks_fetch: assert property (@(posedge clk) disable iff (reset)
        mem_strobe_i |=> !fetch_ack_i)
        else $error("fetch_ack_o after a host main RAM strobe");

endmodule

bind vid_bus_top vid_bus_assert u_vid_bus_assert (
    .clk          (clk),
    .reset        (reset),
    .strobe_i     (strobe_i),
    .write_i      (write_i),
    .mem_strobe_i (mem_strobe),
    .rd_valid_i   (rd_valid_o),
    .fetch_req_i  (fetch_req_i),
    .fetch_ack_i  (fetch_ack_o)
);

//--- verif/tb_vid_bus.sv
`timescale 1ns/1ps

module tb_vid_bus;

    logic        clk;
    logic        reset;
    logic        strobe_i;
    logic        write_i;
    logic [18:0] addr_i;
    logic [7:0]  wrdata_i;
    logic [7:0]  rddata_o;
    logic        rd_valid_o;
    logic        fetch_req_i;
    logic [15:0] fetch_addr_i;
    logic        fetch_ack_o;
    logic [31:0] fetch_rddata_o;
    logic [7:0]  pal_idx_i;
    logic [11:0] pal_rgb_o;

    int errors;
    int tests_ok;
    int tests_bad;

    vid_bus_top u_vid_bus_top (
        .clk            (clk),
        .reset          (reset),
        .strobe_i       (strobe_i),
        .write_i        (write_i),
        .addr_i         (addr_i),
        .wrdata_i       (wrdata_i),
        .rddata_o       (rddata_o),
        .rd_valid_o     (rd_valid_o),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_rddata_o (fetch_rddata_o),
        .pal_idx_i      (pal_idx_i),
        .pal_rgb_o      (pal_rgb_o)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////////////////////////

    // Outputs are sampled and inputs driven 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic host_write(input logic [18:0] addr, input logic [7:0] data);
        strobe_i = 1'b1;
        write_i  = 1'b1;
        addr_i   = addr;
        wrdata_i = data;
        next_cycle();
        strobe_i = 1'b0;
        write_i  = 1'b0;
    endtask

    // Data and valid come the cycle after the strobe and valid drops one cycle later
    task automatic host_read(input string name, input logic [18:0] addr, input logic [7:0] exp);
        strobe_i = 1'b1;
        write_i  = 1'b0;
        addr_i   = addr;
        next_cycle();
        compare(name, 32'd1, 32'(rd_valid_o));
        compare(name, 32'(exp), 32'(rddata_o));
        strobe_i = 1'b0;
        next_cycle();
        compare(name, 32'd0, 32'(rd_valid_o));
    endtask

    // Four random bytes packed little-endian into one word
    task automatic write_word(input logic [14:0] word, output logic [31:0] value);
        value = $urandom;
        for (int i = 0; i < 4; i++) begin
            host_write({2'b00, word, 2'b00} + 19'(i), value[8*i +: 8]);
        end
    endtask

    // Request is already raised and drops in the acknowledge cycle
    task automatic wait_fetch_ack(input string name, input logic [31:0] exp);
        int cycles;
        cycles = 0;
        next_cycle();
        while (!fetch_ack_o && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        if (fetch_ack_o) begin
            compare(name, exp, fetch_rddata_o);
        end else begin
            $display("%s: no fetch acknowledge within %0d cycles", name, cycles);
            errors++;
        end
        fetch_req_i = 1'b0;
    endtask

    task automatic fetch_word(input string name, input logic [15:0] waddr,
                              input logic [31:0] exp);
        fetch_req_i  = 1'b1;
        fetch_addr_i = waddr;
        wait_fetch_ack(name, exp);
    endtask

    function automatic logic [18:0] pal_addr(input logic [7:0] entry, input logic hi);
        return {10'h201, entry, hi};
    endfunction

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            tests_ok++;
            $display("%-14s ok", name);
        end else begin
            tests_bad++;
            $display("%-14s %0d errors", name, errors - start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic byte_lanes();
        logic [14:0] word;
        logic [31:0] value;
        int          start;
        start = errors;
        for (int w = 0; w < 3; w++) begin
            word = 15'($urandom);
            write_word(word, value);
            for (int i = 0; i < 4; i++) begin
                host_read("byte_lanes", {2'b00, word, 2'b00} + 19'(i), value[8*i +: 8]);
            end
        end
        report_test("byte_lanes", start);
    endtask

    task automatic palette_access();
        logic [7:0]  entry [4];
        logic [15:0] value [4];
        logic [7:0]  first;
        int          start;
        start = errors;
        first = 8'($urandom);
        // Stride 61 keeps the four entries apart
        for (int i = 0; i < 4; i++) begin
            entry[i] = first + 8'(61 * i);
            value[i] = 16'($urandom);
            host_write(pal_addr(entry[i], 1'b0), value[i][7:0]);
            host_write(pal_addr(entry[i], 1'b1), value[i][15:8]);
        end
        for (int i = 0; i < 4; i++) begin
            host_read("palette", pal_addr(entry[i], 1'b0), value[i][7:0]);
            host_read("palette", pal_addr(entry[i], 1'b1), value[i][15:8]);
        end
        for (int i = 0; i < 4; i++) begin
            pal_idx_i = entry[i];
            next_cycle();
            compare("palette_rgb", 32'(value[i][11:0]), 32'(pal_rgb_o));
        end
        report_test("palette", start);
    endtask

    task automatic unmapped_region();
        int start;
        start = errors;
        // Main RAM bytes that the unmapped addresses would alias onto
        host_write(19'h00000, 8'h3C);
        host_write(19'h01000, 8'hA5);
        host_write(19'h41000, 8'h5A);
        host_read("unmapped", 19'h20000, 8'h00);
        host_read("unmapped", 19'h40000, 8'h00);
        host_read("unmapped", 19'h41000, 8'h00);
        host_read("unmapped", 19'h01000, 8'hA5);
        report_test("unmapped", start);
    endtask

    task automatic fetch_read();
        logic [14:0] word;
        logic [31:0] value;
        int          start;
        start = errors;
        word = 15'($urandom);
        write_word(word, value);
        fetch_word("fetch", {1'b0, word}, value);
        // Character ROM half
        fetch_word("fetch_rom", {1'b1, word}, 32'h0);
        report_test("fetch", start);
    endtask

    task automatic host_priority();
        logic [14:0] word;
        logic [31:0] value;
        int          start;
        start = errors;
        word = 15'($urandom);
        write_word(word, value);
        strobe_i     = 1'b1;
        write_i      = 1'b0;
        addr_i       = {2'b00, word, 2'b10};
        fetch_req_i  = 1'b1;
        fetch_addr_i = {1'b0, word};
        next_cycle();
        compare("host_priority", 32'd1, 32'(rd_valid_o));
        compare("host_priority", 32'(value[23:16]), 32'(rddata_o));
        compare("host_priority", 32'd0, 32'(fetch_ack_o));
        strobe_i = 1'b0;
        wait_fetch_ack("host_priority", value);
        report_test("host_priority", start);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        strobe_i     = 1'b0;
        write_i      = 1'b0;
        addr_i       = '0;
        wrdata_i     = '0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        pal_idx_i    = '0;
        errors       = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        void'($urandom(2));

        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();

        byte_lanes();
        palette_access();
        unmapped_region();
        fetch_read();
        host_priority();

        $display("Tests: %0d ok, %0d with errors", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hdl/vid_bus_pkg.sv
hdl/regbus_decode.sv
hdl/main_ram.sv
hdl/membus_arbiter.sv
hdl/palette_ram.sv
hdl/rddata_select.sv
hdl/vid_bus_top.sv
verif/vid_bus_assert.sv
verif/tb_vid_bus.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vid_bus -f sim.f

./obj_dir/Vtb_vid_bus | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
